/* autotest_top.f */
logic/sd_host_pkg.sv
logic/autotest_pkg.sv
logic/sd_block_if.sv
logic/sd_transfer.sv
logic/vector_store.sv
logic/test_runner.sv
logic/autotest_top.sv
tests/autotest_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, the exit status carries the result
verilator --binary --timing --timescale 1ns/1ps --top-module autotest_tb \
  -f autotest_top.f -o autotest_sim \
  && ./obj_dir/autotest_sim \
  || exit 1

/* tests/autotest_tests.txt */
// one block per line: signature input expected uut_output mode run_length
// mode 0 ends normally, 1 raises the UUT error, 2 hangs until the DUT timeout
AABBCCDD 12345678 0000A5A5 0000A5A5 0 08
AABBCCDD 0BADF00D 11223344 11223345 0 03
AABBCCDD 00000001 00000002 00000002 1 05
AABBCCDD CAFEBABE DEADBEEF DEADBEEF 2 00
AABBCCDD 80000000 7FFFFFFF 00000000 2 00
AABBCCDD FFFFFFFF 00000000 00000000 0 01
AABBCCDD 13579BDF 2468ACE0 2468ACE0 0 28
AABBCCDD A5A5A5A5 5A5A5A5A 5A5A5A5B 1 02
AABBCCDD 01020304 05060708 05060708 0 FA
AABBCCDD 00C0FFEE 0000BEEF 0000BEEF 1 10
// bad signature, the run stops here
AABBCCDC 11111111 22222222 22222222 0 04
AABBCCDD 33333333 44444444 44444444 0 04

/* tests/autotest_tb.sv */
`timescale 1ns/1ps

module autotest_tb;

  localparam logic [31:0] START_BLOCK = 32'h0010_0000;
  localparam logic [31:0] SIG_VALID   = 32'hAABB_CCDD;
  localparam int          N_LINES     = 12;
  localparam int          BLOCK       = 512;
  // columns of the vector file
  localparam int F_SIG  = 0;
  localparam int F_IN   = 1;
  localparam int F_EXP  = 2;
  localparam int F_OUT  = 3;
  localparam int F_MODE = 4;
  localparam int F_LEN  = 5;
  // every block read and written at most once, under 12 cycles per byte
  localparam int WATCHDOG_CYCLES = 2 * N_LINES * BLOCK * 12 + N_LINES * 400 + 2000;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        spi_busy = 1'b0;
  logic [7:0]  spi_rd_data = 8'h00;
  logic        uut_end = 1'b0;
  logic        uut_err = 1'b0;
  logic [31:0] uut_dout = 32'h0;

  logic [31:0] spi_block_addr;
  logic        spi_rst;
  logic        spi_r_block;
  logic        spi_r_byte;
  logic        spi_w_block;
  logic        spi_w_byte;
  logic [7:0]  spi_wr_data;
  logic        uut_rst;
  logic [31:0] uut_din;
  logic [31:0] error_count;
  logic        halted_o;

  logic [31:0] vec_mem [0:6*N_LINES-1];
  logic [7:0]  written [0:N_LINES*BLOCK-1];
  int          wr_count [0:N_LINES-1];
  logic [31:0] rng;
  logic [7:0]  rd_pending;
  logic        blk_open;
  logic        new_block;
  int          hold;
  int          byte_cnt;
  int          cur_line;
  int          reads_done;
  int          rst_cmds;
  int          run_cnt;
  int          halt_idx;
  int          exp_errors;

  autotest_top #(
    .INPUT_WIDTH(32),
    .OUTPUT_WIDTH(32),
    .TIMEOUT_CYCLES(32'd300),
    .START_BLOCK(START_BLOCK)
  ) i_autotest_top (
    .clk(clk), .rst(rst), .spi_busy_i(spi_busy), .spi_rd_data_i(spi_rd_data),
    .spi_block_addr_o(spi_block_addr), .spi_rst_o(spi_rst), .spi_r_block_o(spi_r_block),
    .spi_r_byte_o(spi_r_byte), .spi_w_block_o(spi_w_block), .spi_w_byte_o(spi_w_byte),
    .spi_wr_data_o(spi_wr_data), .uut_rst_o(uut_rst), .uut_end_i(uut_end),
    .uut_err_i(uut_err), .uut_din_o(uut_din), .uut_dout_i(uut_dout),
    .error_count_o(error_count), .halted_o(halted_o)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] field(input int line, input int col);
    return vec_mem[line * 6 + col];
  endfunction

  function automatic logic line_fails(input int line);
    return field(line, F_OUT) != field(line, F_EXP) || field(line, F_MODE) == 32'd1;
  endfunction

  // signature MSB first, the three words LSB byte first
  function automatic logic [7:0] record_byte(input int line, input int idx, input logic full);
    logic [31:0] w;
    logic [7:0]  b;
    b = 8'hFF;
    if (idx < 4) begin
      w = field(line, F_SIG);
      b = w[(3 - idx) * 8 +: 8];
    end else if (idx < 8) begin
      w = field(line, F_IN);
      b = w[(idx - 4) * 8 +: 8];
    end else if (idx < 12) begin
      w = field(line, F_EXP);
      b = w[(idx - 8) * 8 +: 8];
    end else if (!full) begin
      // card filler past the vector
      b = 8'(idx ^ (idx >> 8) ^ (line * 37));
    end else if (idx < 16) begin
      w = field(line, F_OUT);
      b = w[(idx - 12) * 8 +: 8];
    end else if (idx == 16) begin
      w = field(line, F_MODE);
      b = {6'b0, w == 32'd1, w == 32'd2};
    end
    return b;
  endfunction

  assign new_block = (spi_r_block || spi_w_block) && !blk_open;

  // card behind the SPI host
  always @(posedge clk) begin
    if (rst) begin
      spi_busy   <= 1'b0;
      hold       <= 0;
      blk_open   <= 1'b0;
      byte_cnt   <= 0;
      cur_line   <= 0;
      reads_done <= 0;
      rst_cmds   <= 0;
      rng        <= 32'hf5cb21a7;
      for (int i = 0; i < N_LINES; i++) wr_count[i] <= 0;
    end else begin
      if (!spi_r_block && !spi_w_block) blk_open <= 1'b0;
      if (spi_busy) begin
        if (hold == 1) begin
          spi_busy    <= 1'b0;
          spi_rd_data <= rd_pending;
        end else begin
          hold <= hold - 1;
        end
      end else if (spi_rst || new_block || spi_r_byte || spi_w_byte) begin
        spi_busy <= 1'b1;
        hold     <= int'(rng[1:0]) + 1;
        rng      <= xorshift(rng);
        if (spi_rst) begin
          rst_cmds <= rst_cmds + 1;
        end else if (new_block) begin
          if (halted_o) report_failure("block command issued after halt");
          blk_open <= 1'b1;
          byte_cnt <= 0;
          if (spi_w_block) begin
            check_value("spi_block_addr_o", spi_block_addr, START_BLOCK + cur_line);
            if (!line_fails(cur_line)) report_failure("write-back of a passing block");
          end else begin
            if (reads_done > halt_idx) report_failure("block read past the bad signature");
            check_value("spi_block_addr_o", spi_block_addr, START_BLOCK + reads_done);
            cur_line   <= reads_done;
            reads_done <= reads_done + 1;
          end
        end else begin
          if (byte_cnt >= BLOCK) report_failure("more than 512 byte commands in one block");
          if (spi_r_byte) begin
            rd_pending <= record_byte(cur_line, byte_cnt, 1'b0);
          end else begin
            written[cur_line * BLOCK + byte_cnt] <= spi_wr_data;
            wr_count[cur_line] <= wr_count[cur_line] + 1;
          end
          byte_cnt <= byte_cnt + 1;
        end
      end
    end
  end

  // UUT model
  always @(posedge clk) begin
    if (rst || uut_rst) begin
      run_cnt  <= 0;
      uut_end  <= 1'b0;
      uut_err  <= 1'b0;
      uut_dout <= 32'h0;
    end else begin
      check_value("uut_din_o", uut_din, field(cur_line, F_IN));
      run_cnt  <= run_cnt + 1;
      uut_dout <= field(cur_line, F_OUT);
      // hang mode never ends on its own
      if (field(cur_line, F_MODE) != 32'd2 &&
          run_cnt + 1 >= int'(field(cur_line, F_LEN))) begin
        if (field(cur_line, F_MODE) == 32'd1) uut_err <= 1'b1;
        else uut_end <= 1'b1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure("watchdog expired before the DUT halted");
  end

  initial begin
    $readmemh("tests/autotest_tests.txt", vec_mem);
    halt_idx = N_LINES;
    exp_errors = 0;
    for (int i = N_LINES - 1; i >= 0; i--) begin
      if (field(i, F_SIG) != SIG_VALID) halt_idx = i;
    end
    if (halt_idx == N_LINES) report_failure("vector file has no bad signature line");
    for (int i = 0; i < halt_idx; i++) begin
      if (line_fails(i)) exp_errors = exp_errors + 1;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    while (halted_o !== 1'b1) @(negedge clk);
    check_value("spi_block_addr_o", spi_block_addr, START_BLOCK + halt_idx);
    check_value("error_count_o", error_count, exp_errors);
    check_value("host reset commands", rst_cmds, 1);
    // quiet window, the card flags any late block command
    repeat (200) @(negedge clk);
    for (int i = 0; i < halt_idx; i++) begin
      if (line_fails(i)) begin
        check_value($sformatf("bytes written to block %0d", i), wr_count[i], BLOCK);
        for (int j = 0; j < BLOCK; j++) begin
          check_value($sformatf("spi_wr_data_o block %0d byte %0d", i, j),
                      32'(written[i * BLOCK + j]), 32'(record_byte(i, j, 1'b1)));
        end
      end else begin
        check_value($sformatf("bytes written to block %0d", i), wr_count[i], 0);
      end
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* logic/autotest_top.sv */
`timescale 1ns/1ps

module autotest_top #(
  parameter int          INPUT_WIDTH    = 32,
  parameter int          OUTPUT_WIDTH   = 32,
  parameter logic [31:0] TIMEOUT_CYCLES = 32'h3000_0000,
  parameter logic [31:0] START_BLOCK    = 32'h0010_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    spi_busy_i,
  input  logic [7:0]              spi_rd_data_i,
  output logic [31:0]             spi_block_addr_o,
  output logic                    spi_rst_o,
  output logic                    spi_r_block_o,
  output logic                    spi_r_byte_o,
  output logic                    spi_w_block_o,
  output logic                    spi_w_byte_o,
  output logic [7:0]              spi_wr_data_o,
  output logic                    uut_rst_o,
  input  logic                    uut_end_i,
  input  logic                    uut_err_i,
  output logic [INPUT_WIDTH-1:0]  uut_din_o,
  input  logic [OUTPUT_WIDTH-1:0] uut_dout_i,
  output logic [31:0]             error_count_o,
  output logic                    halted_o
);

  logic        clear;
  logic        capture;
  logic        timeout;
  logic        sig_ok;
  logic        match;
  logic [31:0] block_addr;

  sd_block_if i_bus ();

  sd_transfer i_sd_transfer (
    .clk(clk), .rst(rst), .bus(i_bus.port), .block_addr_i(block_addr),
    .spi_busy_i(spi_busy_i), .spi_rd_data_i(spi_rd_data_i), .spi_rst_o(spi_rst_o),
    .spi_r_block_o(spi_r_block_o), .spi_r_byte_o(spi_r_byte_o),
    .spi_w_block_o(spi_w_block_o), .spi_w_byte_o(spi_w_byte_o),
    .spi_block_addr_o(spi_block_addr_o), .spi_wr_data_o(spi_wr_data_o)
  );

  vector_store #(.INPUT_WIDTH(INPUT_WIDTH), .OUTPUT_WIDTH(OUTPUT_WIDTH)) i_vector_store (
    .clk(clk), .rst(rst), .bus(i_bus.store), .clear_i(clear), .capture_i(capture),
    .uut_dout_i(uut_dout_i), .timeout_i(timeout), .uut_err_i(uut_err_i),
    .uut_din_o(uut_din_o), .sig_ok_o(sig_ok), .match_o(match)
  );

  test_runner #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES), .START_BLOCK(START_BLOCK)) i_test_runner (
    .clk(clk), .rst(rst), .bus(i_bus.runner), .sig_ok_i(sig_ok), .match_i(match),
    .uut_end_i(uut_end_i), .uut_err_i(uut_err_i), .clear_o(clear), .capture_o(capture),
    .timeout_o(timeout), .uut_rst_o(uut_rst_o), .block_addr_o(block_addr),
    .error_count_o(error_count_o), .halted_o(halted_o)
  );

endmodule

/* logic/test_runner.sv */
`timescale 1ns/1ps

module test_runner #(
  parameter logic [31:0]              TIMEOUT_CYCLES = 32'h3000_0000,
  parameter sd_host_pkg::block_addr_t START_BLOCK    = 32'h0010_0000
) (
  input  logic                     clk,
  input  logic                     rst,
  sd_block_if.runner               bus,
  input  logic                     sig_ok_i,
  input  logic                     match_i,
  input  logic                     uut_end_i,
  input  logic                     uut_err_i,
  output logic                     clear_o,
  output logic                     capture_o,
  output logic                     timeout_o,
  output logic                     uut_rst_o,
  output sd_host_pkg::block_addr_t block_addr_o,
  output logic [31:0]              error_count_o,
  output logic                     halted_o
);
  import sd_host_pkg::*;

  localparam logic [3:0] S_READY   = 4'd0;
  localparam logic [3:0] S_CLEAR   = 4'd1;
  localparam logic [3:0] S_LOAD    = 4'd2;
  localparam logic [3:0] S_CHECK   = 4'd3;
  localparam logic [3:0] S_RUN     = 4'd4;
  localparam logic [3:0] S_SETTLE  = 4'd5;
  localparam logic [3:0] S_COMPARE = 4'd6;
  localparam logic [3:0] S_WRITE   = 4'd7;
  localparam logic [3:0] S_NEXT    = 4'd8;
  localparam logic [3:0] S_HALT    = 4'd9;

  logic [3:0]  state_q;
  logic [3:0]  state_d;
  logic [31:0] timer_q;
  logic [31:0] err_q;
  block_addr_t block_q;
  logic        run_done;
  logic        req;
  logic        wr;

  assign timeout_o = timer_q > TIMEOUT_CYCLES;
  assign run_done  = uut_end_i || uut_err_i || timeout_o;

  always_comb begin
    state_d = state_q;
    clear_o = 1'b0;
    req     = 1'b0;
    wr      = 1'b0;
    case (state_q)
      // host reset still running
      S_READY: if (!bus.busy) state_d = S_CLEAR;
      S_CLEAR: begin
        clear_o = 1'b1;
        req     = 1'b1;
        state_d = S_LOAD;
      end
      S_LOAD: if (!bus.busy) state_d = S_CHECK;
      S_CHECK: state_d = sig_ok_i ? S_RUN : S_HALT;
      S_RUN: if (run_done) state_d = S_SETTLE;
      // captured word lands here, match one cycle later
      S_SETTLE: state_d = S_COMPARE;
      S_COMPARE: begin
        if (match_i) begin
          state_d = S_NEXT;
        end else begin
          req     = 1'b1;
          wr      = 1'b1;
          state_d = S_WRITE;
        end
      end
      S_WRITE: if (!bus.busy) state_d = S_NEXT;
      S_NEXT: state_d = S_CLEAR;
      S_HALT: state_d = S_HALT;
      default: state_d = S_READY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_READY;
      timer_q <= '0;
      err_q   <= '0;
      block_q <= START_BLOCK;
    end else begin
      state_q <= state_d;
      if (state_q == S_CHECK) timer_q <= '0;
      else if (state_q == S_RUN) timer_q <= timer_q + 1'b1;
      if (state_q == S_COMPARE && !match_i) err_q <= err_q + 1'b1;
      if (state_q == S_NEXT) block_q <= block_q + 1'b1;
    end
  end

  // sample output and status on the ending cycle
  assign capture_o = state_q == S_RUN && run_done;
  assign uut_rst_o = state_q != S_RUN;
  assign halted_o  = state_q == S_HALT;

  assign bus.req       = req;
  assign bus.wr        = wr;
  assign block_addr_o  = block_q;
  assign error_count_o = err_q;

endmodule

/* logic/vector_store.sv */
`timescale 1ns/1ps

module vector_store #(
  parameter int INPUT_WIDTH  = 32,
  parameter int OUTPUT_WIDTH = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  sd_block_if.store               bus,
  input  logic                    clear_i,
  input  logic                    capture_i,
  input  logic [OUTPUT_WIDTH-1:0] uut_dout_i,
  input  logic                    timeout_i,
  input  logic                    uut_err_i,
  output logic [INPUT_WIDTH-1:0]  uut_din_o,
  output logic                    sig_ok_o,
  output logic                    match_o
);
  import autotest_pkg::*;

  // record layout
  localparam int IN_BYTES  = INPUT_WIDTH / 8;
  localparam int OUT_BYTES = OUTPUT_WIDTH / 8;
  localparam int IN_BASE   = SIG_BYTES;
  localparam int EXP_BASE  = IN_BASE + IN_BYTES;
  localparam int CAP_BASE  = EXP_BASE + OUT_BYTES;
  localparam int STAT_POS  = CAP_BASE + OUT_BYTES;

  logic [8*SIG_BYTES-1:0]  sig_q;
  logic [INPUT_WIDTH-1:0]  din_q;
  logic [OUTPUT_WIDTH-1:0] exp_q;
  logic [OUTPUT_WIDTH-1:0] cap_q;
  logic [7:0]              status_q;
  logic [7:0]              status_d;
  logic                    match_q;
  logic [7:0]              wr_byte_d;
  int                      pos;

  assign pos = int'(bus.idx);

  // signature MSB first, words LSB byte first
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      sig_q <= '0;
      din_q <= '0;
      exp_q <= '0;
    end else if (bus.rd_valid) begin
      if (pos < IN_BASE) sig_q[(SIG_BYTES-1-pos)*8 +: 8] <= bus.rd_byte;
      else if (pos < EXP_BASE) din_q[(pos-IN_BASE)*8 +: 8] <= bus.rd_byte;
      else if (pos < CAP_BASE) exp_q[(pos-EXP_BASE)*8 +: 8] <= bus.rd_byte;
    end
  end

  always_comb begin
    status_d = '0;
    status_d[ST_TIMEOUT] = timeout_i;
    status_d[ST_UUT_ERR] = uut_err_i;
  end

  always_ff @(posedge clk) begin
    if (capture_i) begin
      cap_q    <= uut_dout_i;
      status_q <= status_d;
    end
    // one cycle behind the captured word
    match_q <= (cap_q == exp_q) && !status_q[ST_UUT_ERR];
  end

  // record byte for write-back
  always_comb begin
    if (pos < IN_BASE) wr_byte_d = sig_q[(SIG_BYTES-1-pos)*8 +: 8];
    else if (pos < EXP_BASE) wr_byte_d = din_q[(pos-IN_BASE)*8 +: 8];
    else if (pos < CAP_BASE) wr_byte_d = exp_q[(pos-EXP_BASE)*8 +: 8];
    else if (pos < STAT_POS) wr_byte_d = cap_q[(pos-CAP_BASE)*8 +: 8];
    else if (pos == STAT_POS) wr_byte_d = status_q;
    else wr_byte_d = FILL_BYTE;
  end

  assign bus.wr_byte = wr_byte_d;
  assign uut_din_o   = din_q;
  assign sig_ok_o    = sig_q == SIGNATURE_WORD;
  assign match_o     = match_q;

endmodule

/* logic/sd_transfer.sv */
`timescale 1ns/1ps

module sd_transfer (
  input  logic                     clk,
  input  logic                     rst,
  sd_block_if.port                 bus,
  input  sd_host_pkg::block_addr_t block_addr_i,
  input  logic                     spi_busy_i,
  input  sd_host_pkg::sd_byte_t    spi_rd_data_i,
  output logic                     spi_rst_o,
  output logic                     spi_r_block_o,
  output logic                     spi_r_byte_o,
  output logic                     spi_w_block_o,
  output logic                     spi_w_byte_o,
  output sd_host_pkg::block_addr_t spi_block_addr_o,
  output sd_host_pkg::sd_byte_t    spi_wr_data_o
);
  import sd_host_pkg::*;

  localparam byte_idx_t LAST_IDX = byte_idx_t'(BLOCK_BYTES - 1);

  localparam logic [3:0] S_START     = 4'd0;
  localparam logic [3:0] S_RST_CMD   = 4'd1;
  localparam logic [3:0] S_RST_WAIT  = 4'd2;
  localparam logic [3:0] S_IDLE      = 4'd3;
  localparam logic [3:0] S_BLK_CMD   = 4'd4;
  localparam logic [3:0] S_BLK_WAIT  = 4'd5;
  localparam logic [3:0] S_BYTE_LOAD = 4'd6;
  localparam logic [3:0] S_BYTE_CMD  = 4'd7;
  localparam logic [3:0] S_BYTE_WAIT = 4'd8;
  localparam logic [3:0] S_BYTE_NEXT = 4'd9;

  logic [3:0]  state_q;
  logic        wr_q;
  block_addr_t addr_q;
  byte_idx_t   idx_q;
  logic        rd_valid_q;
  sd_byte_t    rd_byte_q;
  sd_byte_t    wr_data_q;
  logic        in_block;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_START;
      wr_q       <= 1'b0;
      addr_q     <= '0;
      idx_q      <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= 1'b0;
      case (state_q)
        // one host reset before any block traffic
        S_START: state_q <= S_RST_CMD;
        S_RST_CMD: if (spi_busy_i) state_q <= S_RST_WAIT;
        S_RST_WAIT: if (!spi_busy_i) state_q <= S_IDLE;
        S_IDLE: begin
          if (bus.req) begin
            wr_q    <= bus.wr;
            addr_q  <= block_addr_i;
            idx_q   <= '0;
            state_q <= S_BLK_CMD;
          end
        end
        S_BLK_CMD: if (spi_busy_i) state_q <= S_BLK_WAIT;
        S_BLK_WAIT: if (!spi_busy_i) state_q <= S_BYTE_LOAD;
        S_BYTE_LOAD: state_q <= S_BYTE_CMD;
        S_BYTE_CMD: if (spi_busy_i) state_q <= S_BYTE_WAIT;
        S_BYTE_WAIT: begin
          if (!spi_busy_i) begin
            rd_valid_q <= !wr_q;
            state_q    <= S_BYTE_NEXT;
          end
        end
        S_BYTE_NEXT: begin
          // idx still points at the byte just moved
          if (idx_q == LAST_IDX) begin
            state_q <= S_IDLE;
          end else begin
            idx_q   <= idx_q + 1'b1;
            state_q <= S_BYTE_LOAD;
          end
        end
        default: state_q <= S_START;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_BYTE_WAIT && !spi_busy_i) rd_byte_q <= spi_rd_data_i;
    // held until the next byte is loaded
    if (state_q == S_BYTE_LOAD) wr_data_q <= bus.wr_byte;
  end

  assign in_block = state_q inside {S_BLK_CMD, S_BLK_WAIT, S_BYTE_LOAD, S_BYTE_CMD,
                                    S_BYTE_WAIT, S_BYTE_NEXT};

  assign spi_rst_o        = state_q == S_RST_CMD;
  assign spi_r_block_o    = in_block && !wr_q;
  assign spi_w_block_o    = in_block && wr_q;
  assign spi_r_byte_o     = state_q == S_BYTE_CMD && !wr_q;
  assign spi_w_byte_o     = state_q == S_BYTE_CMD && wr_q;
  assign spi_block_addr_o = addr_q;
  assign spi_wr_data_o    = wr_data_q;

  assign bus.busy     = state_q != S_IDLE;
  assign bus.idx      = idx_q;
  assign bus.rd_valid = rd_valid_q;
  assign bus.rd_byte  = rd_byte_q;

endmodule

/* logic/sd_block_if.sv */
`timescale 1ns/1ps

interface sd_block_if;
  import sd_host_pkg::*;

  // block request and direction
  logic      req;
  logic      wr;
  logic      busy;

  // byte stream of the current block
  byte_idx_t idx;
  logic      rd_valid;
  sd_byte_t  rd_byte;
  sd_byte_t  wr_byte;

  modport runner (
    output req,
    output wr,
    input  busy
  );

  modport port (
    output busy,
    output idx,
    output rd_valid,
    output rd_byte,
    input  req,
    input  wr,
    input  wr_byte
  );

  modport store (
    input  idx,
    input  rd_valid,
    input  rd_byte,
    output wr_byte
  );

endinterface

/* logic/autotest_pkg.sv */
package autotest_pkg;

  // marks a block that carries a test vector
  localparam logic [31:0] SIGNATURE_WORD = 32'hAABB_CCDD;

  // signature sits MSB first at the start of the record
  localparam int SIG_BYTES = 4;

  // pad for record bytes past the status byte
  localparam logic [7:0] FILL_BYTE = 8'hFF;

  // status byte bits
  localparam int ST_TIMEOUT = 0;
  localparam int ST_UUT_ERR = 1;

endpackage

/* logic/sd_host_pkg.sv */
package sd_host_pkg;

  // bytes in one SD block
  localparam int BLOCK_BYTES = 512;

  // byte position inside a block, one spare bit
  typedef logic [9:0] byte_idx_t;

  typedef logic [7:0] sd_byte_t;

  // SD block address as seen by the SPI host
  typedef logic [31:0] block_addr_t;

endpackage
